//--- verilog/core_config.svh
// Core-wide width macros, included by every RTL module that sizes data or register ports
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and address width
`define CORE_XLEN 32

// Register file addressing
`define CORE_REG_AW 5
`define CORE_NREGS 32

`endif

//--- verilog/core_pkg.sv
// Instruction layouts and pipeline encodings shared by the core, imported with a wildcard
`default_nettype none

package core_pkg;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_layout_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_layout_t;

    // Branch offset is scattered over both ends of the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_layout_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_layout_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_layout_t;

    // One fetched word, read through whichever layout its opcode selects
    typedef union packed {
        r_layout_t r;
        i_layout_t i;
        b_layout_t b;
        u_layout_t u;
        j_layout_t j;
    } instr_word_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_PASS_B,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_NOP
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_NEXT,
        SEL_JAL,
        SEL_BRANCH
    } sel_pc_t;

endpackage

`default_nettype wire

//--- verilog/if_stage.sv
// Fetch stage: keeps the pc, talks to the instruction memory and drops responses made stale
`default_nettype none
`include "core_config.svh"

module if_stage import core_pkg::*; (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire [`CORE_XLEN-1:0]  reset_addr_i,
    input  wire sel_pc_t          sel_pc_i,
    input  wire [`CORE_XLEN-1:0]  jal_target_i,
    input  wire [`CORE_XLEN-1:0]  branch_target_i,
    input  wire                   ifetch_valid_i,
    input  wire [31:0]            ifetch_instr_i,
    output logic                  ifetch_req_o,
    output logic [`CORE_XLEN-1:0] ifetch_addr_o,
    output logic                  fetch_valid_o,
    output logic [`CORE_XLEN-1:0] fetch_pc_o,
    output logic [31:0]           fetch_instr_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] redirect_pc;
    logic                  run_q;
    logic                  pending_q;
    logic                  stale_q;
    logic                  pending_d;
    logic                  redirect;

    // Low for the first cycle out of reset, while the reset address is loaded
    assign ifetch_req_o  = run_q && !pending_q;
    assign ifetch_addr_o = pc_q;

    assign redirect  = (sel_pc_i != SEL_NEXT);
    assign pending_d = (pending_q && !ifetch_valid_i) || ifetch_req_o;

    always_comb begin
        case (sel_pc_i)
            SEL_JAL:    redirect_pc = jal_target_i;
            SEL_BRANCH: redirect_pc = branch_target_i;
            default:    redirect_pc = pc_q;
        endcase
    end

    // The response belongs to the pc still held in pc_q
    assign fetch_valid_o = ifetch_valid_i && pending_q && !stale_q;
    assign fetch_pc_o    = pc_q;
    assign fetch_instr_o = ifetch_instr_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q      <= '0;
            run_q     <= 1'b0;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            run_q     <= 1'b1;
            pending_q <= pending_d;
            // Whatever is in flight across a redirect was fetched on the old path
            stale_q   <= redirect ? pending_d : (stale_q && pending_d);
            if (!run_q) begin
                pc_q <= reset_addr_i;
            end else if (redirect) begin
                pc_q <= redirect_pc;
            end else if (fetch_valid_o) begin
                pc_q <= pc_q + `CORE_XLEN'd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/decoder.sv
// Decode stage logic: splits a fetched word into operation, registers, immediate and JAL target
`default_nettype none
`include "core_config.svh"

module decoder import core_pkg::*; (
    input  wire [31:0]              instr_i,
    input  wire [`CORE_XLEN-1:0]    pc_i,
    input  wire                     valid_i,
    output alu_op_t                 op_o,
    output logic [`CORE_REG_AW-1:0] rs1_o,
    output logic [`CORE_REG_AW-1:0] rs2_o,
    output logic [`CORE_REG_AW-1:0] rd_o,
    output logic [`CORE_XLEN-1:0]   imm_o,
    output logic                    use_imm_o,
    output logic                    we_o,
    output logic                    jal_valid_o,
    output logic [`CORE_XLEN-1:0]   jal_target_o
);

    instr_word_t           iw;
    logic [`CORE_XLEN-1:0] imm_i_type;
    logic [`CORE_XLEN-1:0] imm_b_type;
    logic [`CORE_XLEN-1:0] imm_u_type;
    logic [`CORE_XLEN-1:0] imm_j_type;

    // Shared by register and immediate arithmetic
    function automatic alu_op_t logic_op(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return OP_ADD;
            3'b100:  return OP_XOR;
            3'b110:  return OP_OR;
            3'b111:  return OP_AND;
            default: return OP_NOP;
        endcase
    endfunction

    assign iw = instr_i;

    assign imm_i_type = {{(`CORE_XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign imm_b_type = {{(`CORE_XLEN-12){iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5,
                         iw.b.imm4_1, 1'b0};
    assign imm_u_type = {iw.u.imm31_12, 12'b0};
    assign imm_j_type = {{(`CORE_XLEN-20){iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11,
                         iw.j.imm10_1, 1'b0};

    assign rs1_o = iw.r.rs1;
    assign rs2_o = iw.r.rs2;
    assign rd_o  = iw.r.rd;

    always_comb begin
        op_o      = OP_NOP;
        imm_o     = '0;
        use_imm_o = 1'b0;
        case (iw.r.opcode)
            OPC_OP: begin
                if (iw.r.funct7 == 7'b0100000 && iw.r.funct3 == 3'b000) begin
                    op_o = OP_SUB;
                end else if (iw.r.funct7 == 7'b0) begin
                    op_o = logic_op(iw.r.funct3);
                end
            end
            OPC_OP_IMM: begin
                op_o      = logic_op(iw.i.funct3);
                imm_o     = imm_i_type;
                use_imm_o = 1'b1;
            end
            OPC_LUI: begin
                op_o      = OP_PASS_B;
                imm_o     = imm_u_type;
                use_imm_o = 1'b1;
            end
            OPC_BRANCH: begin
                // Only BEQ and BNE are implemented
                if (iw.b.funct3 == 3'b000) begin
                    op_o = OP_BEQ;
                end else if (iw.b.funct3 == 3'b001) begin
                    op_o = OP_BNE;
                end
                imm_o = imm_b_type;
            end
            OPC_JAL: begin
                op_o  = OP_JAL;
                imm_o = imm_j_type;
            end
            default: op_o = OP_NOP;
        endcase
    end

    // Write enable already excludes x0
    assign we_o = (rd_o != '0) && !(op_o inside {OP_NOP, OP_BEQ, OP_BNE});

    assign jal_valid_o  = valid_i && (iw.j.opcode == OPC_JAL);
    assign jal_target_o = pc_i + imm_j_type;

endmodule

`default_nettype wire

//--- verilog/regfile.sv
// Integer register file with two read ports and one write port that bypasses to the readers
`default_nettype none
`include "core_config.svh"

module regfile import core_pkg::*; (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  wire                    we_i,
    input  wire [`CORE_REG_AW-1:0] waddr_i,
    input  wire [`CORE_XLEN-1:0]   wdata_i,
    input  wire [`CORE_REG_AW-1:0] raddr1_i,
    input  wire [`CORE_REG_AW-1:0] raddr2_i,
    output logic [`CORE_XLEN-1:0]  rdata1_o,
    output logic [`CORE_XLEN-1:0]  rdata2_o
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];
    logic                  wr_en;

    // x0 is never written
    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible to the reader
    assign rdata1_o = (wr_en && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (wr_en && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- verilog/exe_stage.sv
// Execute stage: write-back bypass, ALU, branch comparison and branch target
`default_nettype none
`include "core_config.svh"

module exe_stage import core_pkg::*; (
    input  wire                    valid_i,
    input  wire alu_op_t           op_i,
    input  wire [`CORE_XLEN-1:0]   pc_i,
    input  wire [`CORE_REG_AW-1:0] rs1_i,
    input  wire [`CORE_REG_AW-1:0] rs2_i,
    input  wire [`CORE_XLEN-1:0]   rs1_data_i,
    input  wire [`CORE_XLEN-1:0]   rs2_data_i,
    input  wire [`CORE_XLEN-1:0]   imm_i,
    input  wire                    use_imm_i,
    input  wire                    wb_we_i,
    input  wire [`CORE_REG_AW-1:0] wb_rd_i,
    input  wire [`CORE_XLEN-1:0]   wb_data_i,
    output logic [`CORE_XLEN-1:0]  result_o,
    output logic                   branch_taken_o,
    output logic [`CORE_XLEN-1:0]  branch_target_o
);

    logic [`CORE_XLEN-1:0] src_a;
    logic [`CORE_XLEN-1:0] src_b_reg;
    logic [`CORE_XLEN-1:0] src_b;
    logic                  bypass_a;
    logic                  bypass_b;
    logic                  equal;

    // Result one stage ahead overrides the value read from the register file
    assign bypass_a = wb_we_i && (wb_rd_i != '0) && (wb_rd_i == rs1_i);
    assign bypass_b = wb_we_i && (wb_rd_i != '0) && (wb_rd_i == rs2_i);

    assign src_a     = bypass_a ? wb_data_i : rs1_data_i;
    assign src_b_reg = bypass_b ? wb_data_i : rs2_data_i;
    assign src_b     = use_imm_i ? imm_i : src_b_reg;

    always_comb begin
        case (op_i)
            OP_ADD:    result_o = src_a + src_b;
            OP_SUB:    result_o = src_a - src_b;
            OP_AND:    result_o = src_a & src_b;
            OP_OR:     result_o = src_a | src_b;
            OP_XOR:    result_o = src_a ^ src_b;
            OP_PASS_B: result_o = src_b;
            // Link address
            OP_JAL:    result_o = pc_i + `CORE_XLEN'd4;
            default:   result_o = '0;
        endcase
    end

    // Branches compare the two register operands
    assign equal = (src_a == src_b_reg);

    assign branch_taken_o  = valid_i && ((op_i == OP_BEQ && equal) ||
                                         (op_i == OP_BNE && !equal));
    assign branch_target_o = pc_i + imm_i;

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
// Pipeline control: picks the fetch redirect and clears the stage registers behind it
`default_nettype none

module control_unit import core_pkg::*; (
    input  wire     jal_valid_i,
    input  wire     branch_taken_i,
    output sel_pc_t sel_pc_o,
    output logic    flush_if_o,
    output logic    flush_id_o,
    output logic    flush_rr_o
);

    // A resolved branch is older than any JAL in decode and wins
    always_comb begin
        if (branch_taken_i) begin
            sel_pc_o = SEL_BRANCH;
        end else if (jal_valid_i) begin
            sel_pc_o = SEL_JAL;
        end else begin
            sel_pc_o = SEL_NEXT;
        end
    end

    // JAL only kills the word being fetched
    assign flush_if_o = branch_taken_i || jal_valid_i;

    // Branch kills everything younger than execute
    assign flush_id_o = branch_taken_i;
    assign flush_rr_o = branch_taken_i;

endmodule

`default_nettype wire

//--- verilog/datapath.sv
// Core top level: holds the IF/ID, ID/RR, RR/EXE and EXE/WB registers and wires the stages
`default_nettype none
`include "core_config.svh"

module datapath import core_pkg::*; (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    input  wire [`CORE_XLEN-1:0]    reset_addr_i,
    input  wire                     ifetch_valid_i,
    input  wire [31:0]              ifetch_instr_i,
    output logic                    ifetch_req_o,
    output logic [`CORE_XLEN-1:0]   ifetch_addr_o,
    output logic                    commit_valid_o,
    output logic [`CORE_XLEN-1:0]   commit_pc_o,
    output logic [`CORE_REG_AW-1:0] commit_rd_o,
    output logic                    commit_we_o,
    output logic [`CORE_XLEN-1:0]   commit_data_o
);

    // Fetch
    logic                    fetch_valid;
    logic [`CORE_XLEN-1:0]   fetch_pc;
    logic [31:0]             fetch_instr;
    logic                    if_id_valid_q;
    logic [`CORE_XLEN-1:0]   if_id_pc_q;
    logic [31:0]             if_id_instr_q;

    // Decode
    alu_op_t                 dec_op;
    logic [`CORE_REG_AW-1:0] dec_rs1;
    logic [`CORE_REG_AW-1:0] dec_rs2;
    logic [`CORE_REG_AW-1:0] dec_rd;
    logic [`CORE_XLEN-1:0]   dec_imm;
    logic                    dec_use_imm;
    logic                    dec_we;
    logic                    jal_valid;
    logic [`CORE_XLEN-1:0]   jal_target;
    logic                    id_rr_valid_q;
    logic [`CORE_XLEN-1:0]   id_rr_pc_q;
    alu_op_t                 id_rr_op_q;
    logic [`CORE_REG_AW-1:0] id_rr_rs1_q;
    logic [`CORE_REG_AW-1:0] id_rr_rs2_q;
    logic [`CORE_REG_AW-1:0] id_rr_rd_q;
    logic [`CORE_XLEN-1:0]   id_rr_imm_q;
    logic                    id_rr_use_imm_q;
    logic                    id_rr_we_q;

    // Register read
    logic [`CORE_XLEN-1:0]   rf_rdata1;
    logic [`CORE_XLEN-1:0]   rf_rdata2;
    logic                    rr_exe_valid_q;
    logic [`CORE_XLEN-1:0]   rr_exe_pc_q;
    alu_op_t                 rr_exe_op_q;
    logic [`CORE_REG_AW-1:0] rr_exe_rs1_q;
    logic [`CORE_REG_AW-1:0] rr_exe_rs2_q;
    logic [`CORE_REG_AW-1:0] rr_exe_rd_q;
    logic [`CORE_XLEN-1:0]   rr_exe_imm_q;
    logic                    rr_exe_use_imm_q;
    logic                    rr_exe_we_q;
    logic [`CORE_XLEN-1:0]   rr_exe_rs1_data_q;
    logic [`CORE_XLEN-1:0]   rr_exe_rs2_data_q;

    // Execute and write-back
    logic [`CORE_XLEN-1:0]   exe_result;
    logic                    branch_taken;
    logic [`CORE_XLEN-1:0]   branch_target;
    logic                    exe_wb_valid_q;
    logic [`CORE_XLEN-1:0]   exe_wb_pc_q;
    logic [`CORE_REG_AW-1:0] exe_wb_rd_q;
    logic                    exe_wb_we_q;
    logic [`CORE_XLEN-1:0]   exe_wb_result_q;
    logic                    wb_we;

    sel_pc_t                 sel_pc;
    logic                    flush_if;
    logic                    flush_id;
    logic                    flush_rr;

    control_unit control_unit_inst (
        .jal_valid_i    (jal_valid),
        .branch_taken_i (branch_taken),
        .sel_pc_o       (sel_pc),
        .flush_if_o     (flush_if),
        .flush_id_o     (flush_id),
        .flush_rr_o     (flush_rr)
    );

    if_stage if_stage_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reset_addr_i    (reset_addr_i),
        .sel_pc_i        (sel_pc),
        .jal_target_i    (jal_target),
        .branch_target_i (branch_target),
        .ifetch_valid_i  (ifetch_valid_i),
        .ifetch_instr_i  (ifetch_instr_i),
        .ifetch_req_o    (ifetch_req_o),
        .ifetch_addr_o   (ifetch_addr_o),
        .fetch_valid_o   (fetch_valid),
        .fetch_pc_o      (fetch_pc),
        .fetch_instr_o   (fetch_instr)
    );

    decoder decoder_inst (
        .instr_i      (if_id_instr_q),
        .pc_i         (if_id_pc_q),
        .valid_i      (if_id_valid_q),
        .op_o         (dec_op),
        .rs1_o        (dec_rs1),
        .rs2_o        (dec_rs2),
        .rd_o         (dec_rd),
        .imm_o        (dec_imm),
        .use_imm_o    (dec_use_imm),
        .we_o         (dec_we),
        .jal_valid_o  (jal_valid),
        .jal_target_o (jal_target)
    );

    regfile regfile_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (wb_we),
        .waddr_i  (exe_wb_rd_q),
        .wdata_i  (exe_wb_result_q),
        .raddr1_i (id_rr_rs1_q),
        .raddr2_i (id_rr_rs2_q),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // Branch outcome only counts for a live instruction in execute
    exe_stage exe_stage_inst (
        .valid_i         (rr_exe_valid_q),
        .op_i            (rr_exe_op_q),
        .pc_i            (rr_exe_pc_q),
        .rs1_i           (rr_exe_rs1_q),
        .rs2_i           (rr_exe_rs2_q),
        .rs1_data_i      (rr_exe_rs1_data_q),
        .rs2_data_i      (rr_exe_rs2_data_q),
        .imm_i           (rr_exe_imm_q),
        .use_imm_i       (rr_exe_use_imm_q),
        .wb_we_i         (wb_we),
        .wb_rd_i         (exe_wb_rd_q),
        .wb_data_i       (exe_wb_result_q),
        .result_o        (exe_result),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    // Valid bits of the four stage registers; a flush turns the entry into a bubble
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            if_id_valid_q  <= 1'b0;
            id_rr_valid_q  <= 1'b0;
            rr_exe_valid_q <= 1'b0;
            exe_wb_valid_q <= 1'b0;
        end else begin
            if_id_valid_q  <= fetch_valid && !flush_if;
            id_rr_valid_q  <= if_id_valid_q && !flush_id;
            rr_exe_valid_q <= id_rr_valid_q && !flush_rr;
            exe_wb_valid_q <= rr_exe_valid_q;
        end
    end

    // Stage payloads advance every cycle, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if_id_pc_q        <= fetch_pc;
        if_id_instr_q     <= fetch_instr;
        id_rr_pc_q        <= if_id_pc_q;
        id_rr_op_q        <= dec_op;
        id_rr_rs1_q       <= dec_rs1;
        id_rr_rs2_q       <= dec_rs2;
        id_rr_rd_q        <= dec_rd;
        id_rr_imm_q       <= dec_imm;
        id_rr_use_imm_q   <= dec_use_imm;
        id_rr_we_q        <= dec_we;
        rr_exe_pc_q       <= id_rr_pc_q;
        rr_exe_op_q       <= id_rr_op_q;
        rr_exe_rs1_q      <= id_rr_rs1_q;
        rr_exe_rs2_q      <= id_rr_rs2_q;
        rr_exe_rd_q       <= id_rr_rd_q;
        rr_exe_imm_q      <= id_rr_imm_q;
        rr_exe_use_imm_q  <= id_rr_use_imm_q;
        rr_exe_we_q       <= id_rr_we_q;
        rr_exe_rs1_data_q <= rf_rdata1;
        rr_exe_rs2_data_q <= rf_rdata2;
        exe_wb_pc_q       <= rr_exe_pc_q;
        exe_wb_rd_q       <= rr_exe_rd_q;
        exe_wb_we_q       <= rr_exe_we_q;
        exe_wb_result_q   <= exe_result;
    end

    assign wb_we = exe_wb_valid_q && exe_wb_we_q;

    // Retirement happens in write-back
    assign commit_valid_o = exe_wb_valid_q;
    assign commit_pc_o    = exe_wb_pc_q;
    assign commit_rd_o    = exe_wb_rd_q;
    assign commit_we_o    = wb_we;
    assign commit_data_o  = exe_wb_result_q;

endmodule

`default_nettype wire

//--- verif/imem_model.sv
// Instruction memory model for the testbench, answers one fetch at a time after a table latency
`default_nettype none
`include "core_config.svh"

module imem_model #(
    parameter int unsigned           DEPTH     = 64,
    parameter int unsigned           LAT_DEPTH = 64,
    parameter logic [`CORE_XLEN-1:0] BASE      = '0
) (
    input  wire                   clk_i,
    input  wire                   req_i,
    input  wire [`CORE_XLEN-1:0]  addr_i,
    output logic                  valid_o,
    output logic [31:0]           instr_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Program words and per-request latencies, loaded by the testbench before reset ends
    logic [31:0] mem [DEPTH];
    int unsigned lat [LAT_DEPTH];

    function automatic logic [31:0] read_word(input logic [`CORE_XLEN-1:0] addr);
        logic [`CORE_XLEN-1:0] idx;
        idx = (addr - BASE) >> 2;
        if (idx < DEPTH) begin
            return mem[idx];
        end
        // Outside the program: ADDI x0 with an immediate folded from the address
        return {addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0}, 20'h00013};
    endfunction

    // Request is sampled mid-cycle, response drives 1 ns after a rising edge
    initial begin : serve
        logic [`CORE_XLEN-1:0] addr;
        int unsigned           n;
        valid_o = 1'b0;
        instr_o = '0;
        n       = 0;
        forever begin
            @(negedge clk_i);
            if (req_i) begin
                addr = addr_i;
                repeat (lat[n % LAT_DEPTH]) @(posedge clk_i);
                n++;
                #1;
                valid_o = 1'b1;
                instr_o = read_word(addr);
                @(posedge clk_i);
                #1;
                valid_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_datapath.sv
// Testbench for the pipeline datapath, runs a random program and checks every commit
`default_nettype none
`include "core_config.svh"

module tb_datapath import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned           SEED        = 80;
    localparam int unsigned           PROG_LEN    = 40;
    localparam int unsigned           NUM_COMMITS = 120;
    localparam int unsigned           LAT_DEPTH   = 64;
    localparam int unsigned           MAX_CYCLES  = NUM_COMMITS * (4 + 6) + 50;
    localparam logic [`CORE_XLEN-1:0] RESET_ADDR  = 32'h0000_1000;

    logic                    clk;
    logic                    rstn;
    logic [`CORE_XLEN-1:0]   reset_addr;
    logic                    ifetch_valid;
    logic [31:0]             ifetch_instr;
    logic                    ifetch_req;
    logic [`CORE_XLEN-1:0]   ifetch_addr;
    logic                    commit_valid;
    logic [`CORE_XLEN-1:0]   commit_pc;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic                    commit_we;
    logic [`CORE_XLEN-1:0]   commit_data;
    logic                    seen_fetch;

    // Program image and architectural state of the reference model
    logic [31:0]           prog [PROG_LEN];
    logic [`CORE_XLEN-1:0] ref_pc;
    logic [`CORE_XLEN-1:0] ref_regs [`CORE_NREGS];

    datapath uut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .reset_addr_i   (reset_addr),
        .ifetch_valid_i (ifetch_valid),
        .ifetch_instr_i (ifetch_instr),
        .ifetch_req_o   (ifetch_req),
        .ifetch_addr_o  (ifetch_addr),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_rd_o    (commit_rd),
        .commit_we_o    (commit_we),
        .commit_data_o  (commit_data)
    );

    imem_model #(.DEPTH(PROG_LEN), .LAT_DEPTH(LAT_DEPTH), .BASE(RESET_ADDR)) imem (
        .clk_i   (clk),
        .req_i   (ifetch_req),
        .addr_i  (ifetch_addr),
        .valid_o (ifetch_valid),
        .instr_o (ifetch_instr)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // funct3 of ADD, AND, OR, XOR in that order
    function automatic logic [2:0] funct3_of(input int unsigned sel);
        case (sel)
            0:       return 3'b000;
            1:       return 3'b111;
            2:       return 3'b110;
            default: return 3'b100;
        endcase
    endfunction

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    // Random ALU, LUI, BEQ, BNE and JAL over x0..x7, jumps only forward, last word loops
    task automatic gen_program();
        instr_word_t w;
        int unsigned kind;
        int unsigned span;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [20:0] off;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = $urandom % 15;
            rd   = 5'($urandom % 8);
            rs1  = 5'($urandom % 8);
            rs2  = ($urandom % 2) ? rs1 : 5'($urandom % 8);
            span = PROG_LEN - 1 - i;
            off  = 21'(4 * (1 + $urandom % (span < 4 ? span : 4)));
            w    = '0;
            if (kind < 5) begin
                w.r.opcode = OPC_OP;
                w.r.funct3 = (kind < 2) ? 3'b000 : funct3_of(kind - 1);
                w.r.funct7 = (kind == 1) ? 7'b0100000 : 7'b0;
                w.r.rd     = rd;
                w.r.rs1    = rs1;
                w.r.rs2    = rs2;
            end else if (kind < 9) begin
                w.i.opcode = OPC_OP_IMM;
                w.i.funct3 = funct3_of(kind - 5);
                w.i.rd     = rd;
                w.i.rs1    = rs1;
                w.i.imm    = 12'($urandom);
            end else if (kind < 11) begin
                w.u.opcode   = OPC_LUI;
                w.u.rd       = rd;
                w.u.imm31_12 = 20'($urandom);
            end else if (kind < 13) begin
                w.b.opcode  = OPC_BRANCH;
                w.b.funct3  = (kind == 11) ? 3'b000 : 3'b001;
                w.b.rs1     = rs1;
                w.b.rs2     = rs2;
                w.b.imm12   = off[12];
                w.b.imm11   = off[11];
                w.b.imm10_5 = off[10:5];
                w.b.imm4_1  = off[4:1];
            end else begin
                w.j.opcode   = OPC_JAL;
                w.j.rd       = rd;
                w.j.imm20    = off[20];
                w.j.imm19_12 = off[19:12];
                w.j.imm11    = off[11];
                w.j.imm10_1  = off[10:1];
            end
            prog[i] = w;
        end
        w          = '0;
        w.j.opcode = OPC_JAL;
        w.j.rd     = 5'($urandom % 8);
        prog[PROG_LEN-1] = w;
    endtask

    // Executes the instruction at ref_pc and returns what its commit must show
    function automatic void ref_step(output logic [31:0] pc, output logic [4:0] rd,
                                     output logic we, output logic [31:0] data);
        instr_word_t w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] next_pc;
        logic        writes;
        logic        taken;
        w       = prog[(ref_pc - RESET_ADDR) >> 2];
        a       = ref_regs[w.r.rs1];
        b       = ref_regs[w.r.rs2];
        data    = '0;
        writes  = 1'b0;
        next_pc = ref_pc + 32'd4;
        case (w.r.opcode)
            OPC_OP: begin
                data   = arith(w.r.funct3, w.r.funct7[5], a, b);
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                imm    = {{20{w.i.imm[11]}}, w.i.imm};
                data   = arith(w.i.funct3, 1'b0, a, imm);
                writes = 1'b1;
            end
            OPC_LUI: begin
                data   = {w.u.imm31_12, 12'b0};
                writes = 1'b1;
            end
            OPC_BRANCH: begin
                imm   = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
                taken = (w.b.funct3 == 3'b000) ? (a == b) : (a != b);
                if (taken) begin
                    next_pc = ref_pc + imm;
                end
            end
            OPC_JAL: begin
                imm     = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
                data    = ref_pc + 32'd4;
                writes  = 1'b1;
                next_pc = ref_pc + imm;
            end
            default: ;
        endcase
        pc = ref_pc;
        rd = w.r.rd;
        we = writes && (w.r.rd != 5'd0);
        if (we) begin
            ref_regs[w.r.rd] = data;
        end
        ref_pc = next_pc;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : stimulus
        void'($urandom(SEED));
        rstn       = 1'b0;
        reset_addr = RESET_ADDR;
        seen_fetch = 1'b0;
        ref_pc     = RESET_ADDR;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            ref_regs[r] = '0;
        end
        gen_program();
        for (int k = 0; k < PROG_LEN; k++) begin
            imem.mem[k] = prog[k];
        end
        for (int k = 0; k < LAT_DEPTH; k++) begin
            imem.lat[k] = 1 + $urandom % 4;
        end
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

    always @(posedge clk) begin
        if (ifetch_valid) begin
            seen_fetch <= 1'b1;
        end
    end

    // Fetch port: quiet in reset, first request one cycle after release, one in flight
    initial begin : fetch_port
        logic        outstanding;
        int unsigned since_reset;
        outstanding = 1'b0;
        since_reset = 0;
        // The first edge clears the flops before anything is sampled
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (!rstn) begin
                assert (!ifetch_req && !commit_valid) else begin
                    stop_with_failure("fetch request or commit raised while in reset");
                end
            end else begin
                since_reset++;
                if (since_reset == 1) begin
                    assert (!ifetch_req) else begin
                        stop_with_failure("fetch request raised in the cycle reset was released");
                    end
                end
                if (since_reset == 2) begin
                    assert (ifetch_req) else begin
                        stop_with_failure("no fetch request one cycle after reset release");
                    end
                    check_value("ifetch_addr_o", ifetch_addr, reset_addr);
                end
                if (ifetch_valid) begin
                    outstanding = 1'b0;
                end
                if (ifetch_req) begin
                    assert (!outstanding) else begin
                        stop_with_failure("fetch request issued while another is outstanding");
                    end
                    outstanding = 1'b1;
                end
            end
        end
    end

    // Commit outputs come from flops, so the middle of the cycle is stable
    initial begin : compare_commits
        logic [31:0] exp_pc;
        logic [31:0] exp_data;
        logic [4:0]  exp_rd;
        logic        exp_we;
        int unsigned count;
        count = 0;
        while (count < NUM_COMMITS) begin
            @(negedge clk);
            if (commit_valid) begin
                assert (seen_fetch) else begin
                    stop_with_failure("commit seen before the first fetch response");
                end
                if (count == 0) begin
                    check_value("commit_pc_o", commit_pc, reset_addr);
                end
                ref_step(exp_pc, exp_rd, exp_we, exp_data);
                check_value("commit_pc_o", commit_pc, exp_pc);
                check_value("commit_we_o", 32'(commit_we), 32'(exp_we));
                if (exp_we) begin
                    check_value("commit_rd_o", 32'(commit_rd), 32'(exp_rd));
                    check_value("commit_data_o", commit_data, exp_data);
                end
                count++;
            end
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_failure($sformatf("timeout after %0d cycles, fewer than %0d commits seen",
                                    cycles, NUM_COMMITS));
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/exe_stage.sv
verilog/control_unit.sv
verilog/datapath.sv
verif/imem_model.sv
verif/tb_datapath.sv
